/* Makefile */
TOP = bridge_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "test failed" sim.log; then \
		exit 1; \
	fi
	@if ! grep -q "test passed" sim.log; then \
		echo "simulation ended without a result line"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* list.f */
src/line_pkg.sv
src/port_arbiter.sv
src/beat_counter.sv
src/line_assembler.sv
src/line_serializer.sv
src/line_mem_bridge.sv
tests/burst_mem_model.sv
tests/bridge_tb.sv

/* src/beat_counter.sv */
`timescale 1ns/1ps

module beat_counter import line_pkg::*; (
    input  logic      itf,
    input  logic      reset,
    input  logic      start,
    input  logic      mem_resp,
    output beat_idx_t beat,
    output logic      last_beat
);

    // index of the final beat in a line
    localparam beat_idx_t LAST_IDX = beat_idx_t'(BEATS_PER_LINE - 1);

    always_ff @(posedge itf) begin
        if (reset) begin
            beat <= '0;
        end else if (start) begin
            // fresh burst
            beat <= '0;
        end else if (mem_resp) begin
            // wraps back to 0 after beat 3
            beat <= beat + beat_idx_t'(1);
        end
    end

    // combinational, so the arbiter sees it in the beat 3 resp cycle
    assign last_beat = (beat == LAST_IDX);

endmodule

/* src/line_assembler.sv */
`timescale 1ns/1ps

module line_assembler import line_pkg::*; (
    input  logic  itf,
    input  logic  capture,
    input  beat_t mem_burst_rdata,
    output line_t line
);

    // line built up in place
    line_t shift_q;

    // each beat enters at the top and pushes the rest down,
    // so beat 0 ends up in the low word after the fourth one
    always_ff @(posedge itf) begin
        if (capture) begin
            shift_q <= {mem_burst_rdata, shift_q[LINE_W-1:BEAT_W]};
        end
    end

    // holds after the burst until the next fill
    assign line = shift_q;

endmodule

/* src/line_mem_bridge.sv */
`timescale 1ns/1ps

module line_mem_bridge import line_pkg::*; (
    input  logic  itf,
    input  logic  reset,

    // instruction cache port
    input  logic  inst_read,
    input  addr_t inst_addr,
    output line_t inst_rdata,
    output logic  inst_resp,

    // data cache port
    input  logic  data_read,
    input  logic  data_write,
    input  addr_t data_addr,
    input  line_t data_wdata,
    output line_t data_rdata,
    output logic  data_resp,

    // shared burst bus
    output addr_t mem_addr,
    output logic  mem_read,
    output logic  mem_write,
    output beat_t mem_burst_wdata,
    input  beat_t mem_burst_rdata,
    input  logic  mem_resp
);

    arb_state_t state;
    logic       start;
    logic       last_beat;
    beat_idx_t  beat;
    logic       capture;
    logic       load_wdata;
    logic       advance;
    line_t      fill_line;

    port_arbiter arbiter_i (
        .itf        (itf),
        .reset      (reset),
        .inst_read  (inst_read),
        .data_read  (data_read),
        .data_write (data_write),
        .last_beat  (last_beat),
        .mem_resp   (mem_resp),
        .state      (state),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .inst_resp  (inst_resp),
        .data_resp  (data_resp),
        .start      (start)
    );

    beat_counter counter_i (
        .itf       (itf),
        .reset     (reset),
        .start     (start),
        .mem_resp  (mem_resp),
        .beat      (beat),
        .last_beat (last_beat)
    );

    // read beats only while a fill is running
    assign capture = mem_resp && mem_read;

    line_assembler assembler_i (
        .itf             (itf),
        .capture         (capture),
        .mem_burst_rdata (mem_burst_rdata),
        .line            (fill_line)
    );

    // data has priority, so a start with a write pending is always an eviction
    assign load_wdata = start && data_write;
    assign advance    = mem_resp && mem_write;

    line_serializer serializer_i (
        .itf             (itf),
        .start           (load_wdata),
        .advance         (advance),
        .data_wdata      (data_wdata),
        .mem_burst_wdata (mem_burst_wdata)
    );

    // address follows the granted port
    always_comb begin
        unique case (state)
            inst_fill:             mem_addr = inst_addr;
            data_fill, data_evict: mem_addr = data_addr;
            default:               mem_addr = '0;
        endcase
    end

    // same line goes to both clients and resp says who owns it
    assign inst_rdata = fill_line;
    assign data_rdata = fill_line;

    // memory must stay quiet unless a burst is open
    no_idle_resp: assert property (@(posedge itf) disable iff (reset)
        !((state == idle) && mem_resp));

    // memory sends the four beats back to back
    beats_back_to_back: assert property (@(posedge itf) disable iff (reset)
        (mem_resp && (beat != beat_idx_t'(BEATS_PER_LINE - 1))) |=> mem_resp);

endmodule

/* src/line_pkg.sv */
package line_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int BEAT_W = 64;

    // a line is four burst beats
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_W = BEAT_W * BEATS_PER_LINE;
    localparam int BEAT_IDX_W = $clog2(BEATS_PER_LINE);

    // byte address, line aligned to 32 bytes on the memory side
    typedef logic [ADDR_W-1:0] addr_t;

    // one word of a burst
    typedef logic [BEAT_W-1:0] beat_t;

    // full cache line, beat 0 in the low bits
    typedef logic [LINE_W-1:0] line_t;

    // which beat of the burst we are on
    typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

    // arbiter states
    typedef enum logic [1:0] {
        idle,
        inst_fill,
        data_fill,
        data_evict
    } arb_state_t;

endpackage

/* src/line_serializer.sv */
`timescale 1ns/1ps

module line_serializer import line_pkg::*; (
    input  logic  itf,
    input  logic  start,
    input  logic  advance,
    input  line_t data_wdata,
    output beat_t mem_burst_wdata
);

    // remaining write data, current beat in the low word
    line_t hold_q;

    always_ff @(posedge itf) begin
        if (start) begin
            // grab the eviction line as the burst opens
            hold_q <= data_wdata;
        end else if (advance) begin
            // memory took the low word, move the next one down
            hold_q <= {beat_t'(0), hold_q[LINE_W-1:BEAT_W]};
        end
    end

    // beat on the bus right now
    assign mem_burst_wdata = hold_q[BEAT_W-1:0];

endmodule

/* src/port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter import line_pkg::*; (
    input  logic       itf,
    input  logic       reset,
    input  logic       inst_read,
    input  logic       data_read,
    input  logic       data_write,
    input  logic       last_beat,
    input  logic       mem_resp,
    output arb_state_t state,
    output logic       mem_read,
    output logic       mem_write,
    output logic       inst_resp,
    output logic       data_resp,
    output logic       start
);

    arb_state_t next_state;
    logic       accept;
    logic       burst_done;

    // a client still sees its request high during its resp cycle,
    // so nothing is granted until the pulse is gone
    assign accept = (state == idle) && !inst_resp && !data_resp;

    // fourth beat of the burst on the bus
    assign burst_done = mem_resp && last_beat;

    always_comb begin
        next_state = state;
        unique case (state)
            idle: begin
                // data port wins a tie
                if (accept && data_write) begin
                    next_state = data_evict;
                end else if (accept && data_read) begin
                    next_state = data_fill;
                end else if (accept && inst_read) begin
                    next_state = inst_fill;
                end
            end
            inst_fill, data_fill, data_evict: begin
                if (burst_done) begin
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    // one cycle pulse on the grant edge
    assign start = (state == idle) && (next_state != idle);

    // strobes held for the whole burst, decoded straight from state
    assign mem_read  = (state == inst_fill) || (state == data_fill);
    assign mem_write = (state == data_evict);

    always_ff @(posedge itf) begin
        if (reset) begin
            state     <= idle;
            inst_resp <= 1'b0;
            data_resp <= 1'b0;
        end else begin
            state     <= next_state;
            // client resp lands one cycle after the last beat
            inst_resp <= burst_done && (state == inst_fill);
            data_resp <= burst_done && ((state == data_fill) || (state == data_evict));
        end
    end

    // one bus direction at a time
    rw_exclusive: assert property (@(posedge itf) disable iff (reset)
        !(mem_read && mem_write));

    // only one client answered per burst
    resp_exclusive: assert property (@(posedge itf) disable iff (reset)
        !(inst_resp && data_resp));

endmodule

/* tests/bridge_tb.sv */
`timescale 1ns/1ps

module bridge_tb import line_pkg::*; ();

    localparam int NUM_TRANS       = 300;
    localparam int WATCHDOG_CYCLES = NUM_TRANS * 40;

    logic       itf;
    logic       reset;
    logic       inst_read;
    addr_t      inst_addr;
    line_t      inst_rdata;
    logic       inst_resp;
    logic       data_read;
    logic       data_write;
    addr_t      data_addr;
    line_t      data_wdata;
    line_t      data_rdata;
    logic       data_resp;
    addr_t      mem_addr;
    logic       mem_read;
    logic       mem_write;
    beat_t      mem_burst_wdata;
    beat_t      mem_burst_rdata;
    logic       mem_resp;
    logic [2:0] mem_delay;

    // reference copy of memory
    line_t       shadow [16];
    logic [31:0] lcg_state;
    // port status is 0 free, 1 waiting or 2 answered
    int          inst_state;
    int          data_state;
    logic        data_is_write;
    // burst owner is 0 none, 1 inst or 2 data
    int          owner;
    logic        strobe_prev;
    // beats seen in the current burst
    int          bus_beat;
    logic        tie_pending;
    int          issued;
    int          answered;
    int          value_errors;
    int          protocol_errors;

    line_mem_bridge dut_i (
        .itf             (itf),
        .reset           (reset),
        .inst_read       (inst_read),
        .inst_addr       (inst_addr),
        .inst_rdata      (inst_rdata),
        .inst_resp       (inst_resp),
        .data_read       (data_read),
        .data_write      (data_write),
        .data_addr       (data_addr),
        .data_wdata      (data_wdata),
        .data_rdata      (data_rdata),
        .data_resp       (data_resp),
        .mem_addr        (mem_addr),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_burst_wdata (mem_burst_wdata),
        .mem_burst_rdata (mem_burst_rdata),
        .mem_resp        (mem_resp)
    );

    burst_mem_model mem_i (
        .itf             (itf),
        .reset           (reset),
        .delay           (mem_delay),
        .mem_addr        (mem_addr),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_burst_wdata (mem_burst_wdata),
        .mem_burst_rdata (mem_burst_rdata),
        .mem_resp        (mem_resp)
    );

    initial begin
        itf = 1'b0;
        forever #5 itf = ~itf;
    end

    // hard stop if the bridge wedges
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge itf);
        $display("timeout: transactions still open after %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic addr_t line_addr(input logic [3:0] line_no);
        return {23'd0, line_no, 5'd0};
    endfunction

    // memory starts out as a function of each beat's byte address
    function automatic line_t initial_line(input addr_t base);
        line_t line;
        addr_t a;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            a = base + addr_t'(b * 8);
            line[b*BEAT_W +: BEAT_W] = {a ^ 32'ha5c3_0f00, a * 32'h9e37_79b9};
        end
        return line;
    endfunction

    function automatic line_t random_line();
        line_t line;
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = next_rand();
        end
        return line;
    endfunction

    // bus and response checks for the current cycle
    task automatic observe_cycle();
        logic strobe;
        strobe = mem_read || mem_write;
        if (mem_read && mem_write) begin
            $display("mem_read and mem_write are high together at %0t", $time);
            protocol_errors++;
        end
        // new burst goes to the data port first on a tie
        if (strobe && !strobe_prev) begin
            bus_beat = 0;
            if (data_state == 1) begin
                owner = 2;
            end else if (inst_state == 1) begin
                owner = 1;
            end else begin
                owner = 0;
                $display("memory burst started with no request pending at %0t", $time);
                protocol_errors++;
            end
        end
        if (strobe && owner == 2) begin
            if (mem_addr !== data_addr) begin
                $display("Error: mem_addr = %h, expected %h", mem_addr, data_addr);
                value_errors++;
            end
            if (mem_write !== data_is_write) begin
                $display("Error: mem_write = %h, expected %h", mem_write, data_is_write);
                value_errors++;
            end
        end else if (strobe && owner == 1) begin
            if (mem_addr !== inst_addr) begin
                $display("Error: mem_addr = %h, expected %h", mem_addr, inst_addr);
                value_errors++;
            end
            if (mem_write !== 1'b0) begin
                $display("Error: mem_write = %h, expected %h", mem_write, 1'b0);
                value_errors++;
            end
        end
        // write beats leave lowest first
        if (strobe && mem_resp) begin
            if (mem_write && owner == 2 &&
                mem_burst_wdata !== data_wdata[bus_beat*BEAT_W +: BEAT_W]) begin
                $display("Error: mem_burst_wdata = %h, expected %h",
                         mem_burst_wdata, data_wdata[bus_beat*BEAT_W +: BEAT_W]);
                value_errors++;
            end
            bus_beat++;
        end
        strobe_prev = strobe;
        if (inst_resp) begin
            answered++;
            if (tie_pending && data_state == 1) begin
                $display("inst_resp came before data_resp after a tie at %0t", $time);
                protocol_errors++;
            end
            if (inst_state != 1 || owner != 1) begin
                $display("inst_resp without a matching instruction burst at %0t", $time);
                protocol_errors++;
            end else begin
                if (inst_rdata !== shadow[inst_addr[8:5]]) begin
                    $display("Error: inst_rdata = %h, expected %h",
                             inst_rdata, shadow[inst_addr[8:5]]);
                    value_errors++;
                end
                inst_state = 2;
            end
        end
        if (data_resp) begin
            answered++;
            if (data_state != 1 || owner != 2) begin
                $display("data_resp without a matching data burst at %0t", $time);
                protocol_errors++;
            end else begin
                // writes land in the shadow only once acknowledged
                if (data_is_write) begin
                    shadow[data_addr[8:5]] = data_wdata;
                end else if (data_rdata !== shadow[data_addr[8:5]]) begin
                    $display("Error: data_rdata = %h, expected %h",
                             data_rdata, shadow[data_addr[8:5]]);
                    value_errors++;
                end
                tie_pending = 1'b0;
                data_state  = 2;
            end
        end
    endtask

    // new random requests, and requests dropped a cycle after resp
    task automatic drive_cycle();
        logic [31:0] r;
        logic        inst_new;
        logic        data_new;
        inst_new  = 1'b0;
        data_new  = 1'b0;
        r         = next_rand();
        mem_delay = 3'(r[31:16] % 16'd6);
        if (inst_state == 2) begin
            inst_read  = 1'b0;
            inst_state = 0;
        end else if (inst_state == 0 && issued < NUM_TRANS) begin
            r = next_rand();
            if (r[31]) begin
                inst_addr  = line_addr(r[27:24]);
                inst_read  = 1'b1;
                inst_state = 1;
                inst_new   = 1'b1;
                issued++;
            end
        end
        if (data_state == 2) begin
            data_read  = 1'b0;
            data_write = 1'b0;
            data_state = 0;
        end else if (data_state == 0 && issued < NUM_TRANS) begin
            r = next_rand();
            if (r[31]) begin
                data_addr     = line_addr(r[27:24]);
                data_is_write = r[30];
                if (r[30]) begin
                    data_wdata = random_line();
                end
                data_read  = !r[30];
                data_write = r[30];
                data_state = 1;
                data_new   = 1'b1;
                issued++;
            end
        end
        if (inst_new && data_new) begin
            tie_pending = 1'b1;
        end
    endtask

    initial begin
        reset           = 1'b1;
        inst_read       = 1'b0;
        inst_addr       = '0;
        data_read       = 1'b0;
        data_write      = 1'b0;
        data_addr       = '0;
        data_wdata      = '0;
        mem_delay       = '0;
        lcg_state       = 32'hdf18;
        inst_state      = 0;
        data_state      = 0;
        data_is_write   = 1'b0;
        owner           = 0;
        strobe_prev     = 1'b0;
        bus_beat        = 0;
        tie_pending     = 1'b0;
        issued          = 0;
        answered        = 0;
        value_errors    = 0;
        protocol_errors = 0;
        for (int l = 0; l < 16; l++) begin
            shadow[l] = initial_line(line_addr(4'(l)));
        end
        repeat (5) @(posedge itf);
        #1 reset = 1'b0;
        // quiet bus with no requests
        repeat (8) begin
            @(posedge itf);
            #1;
            if (mem_read || mem_write || inst_resp || data_resp) begin
                $display("bus or response active after reset with no request at %0t", $time);
                protocol_errors++;
            end
        end
        while (issued < NUM_TRANS || inst_state != 0 || data_state != 0) begin
            @(posedge itf);
            #1;
            observe_cycle();
            drive_cycle();
        end
        if (answered != issued) begin
            $display("%0d responses for %0d requests", answered, issued);
            protocol_errors++;
        end
        $display("summary: %0d requests, %0d responses, %0d value errors, %0d protocol errors",
                 issued, answered, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* tests/burst_mem_model.sv */
`timescale 1ns/1ps

module burst_mem_model import line_pkg::*; (
    input  logic       itf,
    input  logic       reset,
    input  logic [2:0] delay,
    input  addr_t      mem_addr,
    input  logic       mem_read,
    input  logic       mem_write,
    input  beat_t      mem_burst_wdata,
    output beat_t      mem_burst_rdata,
    output logic       mem_resp
);

    // 16 lines, four beats each
    beat_t      store [16][BEATS_PER_LINE];
    logic       active;
    logic [2:0] wait_cnt;
    beat_idx_t  beat_no;
    logic [3:0] line_sel;

    // contents depend on every address bit
    function automatic beat_t initial_word(input addr_t byte_addr);
        return {byte_addr ^ 32'ha5c3_0f00, byte_addr * 32'h9e37_79b9};
    endfunction

    assign line_sel        = mem_addr[8:5];
    assign mem_burst_rdata = store[line_sel][beat_no];

    always @(posedge itf) begin
        if (reset) begin
            active   <= 1'b0;
            mem_resp <= 1'b0;
            wait_cnt <= '0;
            beat_no  <= '0;
            for (int l = 0; l < 16; l++) begin
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    store[l][b] <= initial_word(addr_t'(l * 32 + b * 8));
                end
            end
        end else begin
            // write beat taken at the end of its resp cycle
            if (mem_resp && mem_write) begin
                store[line_sel][beat_no] <= mem_burst_wdata;
            end
            if (!active) begin
                // latch the delay as the strobe first shows up
                if (mem_read || mem_write) begin
                    active   <= 1'b1;
                    wait_cnt <= delay;
                    beat_no  <= '0;
                end
            end else if (wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;
            end else if (!mem_resp) begin
                mem_resp <= 1'b1;
            end else if (beat_no == 2'd3) begin
                // four beats sent, go quiet
                mem_resp <= 1'b0;
                active   <= 1'b0;
                beat_no  <= '0;
            end else begin
                beat_no <= beat_no + 2'd1;
            end
        end
    end

endmodule
